// File: hdl/eth_rx_pkg.sv
package eth_rx_pkg;

   // station address, first byte on the wire in the top bits
   localparam logic [47:0] eth_mac_addr = 48'h02_12_34_56_78_9a;

   localparam logic [7:0] eth_sfd = 8'hd5;

   // remainder left in the CRC register after a clean FCS
   localparam logic [31:0] eth_crc_residue = 32'hc704dd7b;
   localparam logic [31:0] eth_crc_poly = 32'h04c1_1db7;

   localparam int eth_hdr_bytes = 14;
   localparam int eth_fcs_bytes = 4;

   // 2048 byte frame buffer
   localparam int eth_buf_aw = 11;

   // index of the last destination byte
   localparam logic [eth_buf_aw-1:0] eth_dst_last = eth_buf_aw'(5);

   // last frame address minus the payload length
   localparam logic [eth_buf_aw-1:0] eth_tail_ofs =
      eth_buf_aw'(eth_hdr_bytes + eth_fcs_bytes - 1);

   // write port into the buffer, RX_CLK domain
   typedef struct packed {
      logic [eth_buf_aw-1:0] addr;
      logic [7:0]            data;
      logic                  wr;
   } rx_wr_t;

endpackage

// File: hdl/eth_rx_cdc.sv
module eth_rx_cdc (
   input  logic                             RX_CLK,
   input  logic                             clk,
   input  logic                             rx_rst,
   input  logic                             rcv_ack,
   input  logic [eth_rx_pkg::eth_buf_aw-1:0] nbytes,
   input  logic                             frame_ok,
   output logic                             rx_rst_sync,
   output logic                             ack_sync,
   output logic [eth_rx_pkg::eth_buf_aw-1:0] nbytes_rx,
   output logic                             data_rcvd
);

   logic [1:0]                         rst_q;
   logic [1:0]                         ack_q;
   logic [1:0]                         ok_q;
   logic [eth_rx_pkg::eth_buf_aw-1:0] nbytes_q;

   // reset goes in at once, comes out on RX_CLK
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         rst_q <= 2'b11;
      end else begin
         rst_q <= {rst_q[0], 1'b0};
      end
   end

   assign rx_rst_sync = rst_q[1];

   // ack pulse presets, then drains after two edges
   always_ff @(posedge RX_CLK or posedge rcv_ack) begin
      if (rcv_ack) begin
         ack_q <= 2'b11;
      end else begin
         ack_q <= {ack_q[0], 1'b0};
      end
   end

   assign ack_sync = ack_q[1];

   // nbytes is quasi-static during a frame
   always_ff @(posedge RX_CLK) begin
      nbytes_q  <= nbytes;
      nbytes_rx <= nbytes_q;
   end

   // frame_ok level into the system domain
   always_ff @(posedge clk or posedge rx_rst) begin
      if (rx_rst) begin
         ok_q <= 2'b00;
      end else begin
         ok_q <= {ok_q[0], frame_ok};
      end
   end

   assign data_rcvd = ok_q[1];

   // no stale flag may leak out of a reset
   a_rcvd_after_rst: assert property (@(posedge clk) rx_rst |=> !data_rcvd);

endmodule

// File: hdl/eth_crc32.sv
module eth_crc32 (
   input  logic        RX_CLK,
   input  logic        rx_rst_sync,
   input  logic        crc_start,
   input  logic        crc_en,
   input  logic [7:0]  crc_byte,
   output logic [31:0] crc_value
);

   // one byte, bit 0 first as it leaves the wire
   function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] b);
      logic [31:0] c;
      logic        fb;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         fb = c[31] ^ b[i];
         c  = {c[30:0], 1'b0};
         if (fb) begin
            c = c ^ eth_rx_pkg::eth_crc_poly;
         end
      end
      return c;
   endfunction

   // preset to all ones between frames
   always_ff @(posedge RX_CLK or posedge rx_rst_sync) begin
      if (rx_rst_sync) begin
         crc_value <= '1;
      end else if (crc_start) begin
         crc_value <= '1;
      end else if (crc_en) begin
         crc_value <= crc_next(crc_value, crc_byte);
      end
   end

endmodule

// File: hdl/eth_frame_rx.sv
module eth_frame_rx (
   input  logic                             RX_CLK,
   input  logic                             rx_rst_sync,
   input  logic                             RX_DV,
   input  logic [3:0]                       RX_DATA,
   input  logic [eth_rx_pkg::eth_buf_aw-1:0] nbytes_rx,
   input  logic                             ack_sync,
   input  logic [31:0]                      crc_value,
   output eth_rx_pkg::rx_wr_t               rx_wr,
   output logic                             crc_start,
   output logic                             frame_ok
);

   typedef enum logic [2:0] {
      st_hunt,
      st_sync,
      st_dst_byte,
      st_dst_next,
      st_body_byte,
      st_body_next,
      st_verdict,
      st_hold
   } state_t;

   state_t                             state;
   logic [7:0]                         data_int;
   logic [7:0]                         byte_q;
   logic [eth_rx_pkg::eth_buf_aw-1:0] addr_q;
   logic                               wr_q;
   logic [47:0]                        dst_addr;
   logic                               line_idle;
   logic [eth_rx_pkg::eth_buf_aw-1:0] last_addr;

   // low nibble arrives first and moves down
   assign data_int = {RX_DATA, byte_q[7:4]};

   always_ff @(posedge RX_CLK) begin
      if (RX_DV) begin
         byte_q <= data_int;
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (state == st_dst_byte) begin
         dst_addr <= {dst_addr[39:0], data_int};
      end
   end

   assign last_addr = nbytes_rx + eth_rx_pkg::eth_tail_ofs;

   always_ff @(posedge RX_CLK or posedge rx_rst_sync) begin
      if (rx_rst_sync) begin
         state     <= st_hunt;
         addr_q    <= '0;
         wr_q      <= 1'b0;
         frame_ok  <= 1'b0;
         line_idle <= 1'b0;
      end else begin
         wr_q <= 1'b0;
         case (state)
            // sfd only counts after the line has been idle
            st_hunt: begin
               if (!RX_DV) begin
                  line_idle <= 1'b1;
               end else if (line_idle && data_int == eth_rx_pkg::eth_sfd) begin
                  state <= st_sync;
               end
            end
            st_sync: begin
               addr_q    <= '0;
               line_idle <= 1'b0;
               state     <= st_dst_byte;
            end
            st_dst_byte: begin
               wr_q  <= 1'b1;
               state <= st_dst_next;
            end
            st_dst_next: begin
               addr_q <= addr_q + 1'b1;
               if (addr_q != eth_rx_pkg::eth_dst_last) begin
                  state <= st_dst_byte;
               end else if (dst_addr != eth_rx_pkg::eth_mac_addr) begin
                  state <= st_hunt;
               end else begin
                  state <= st_body_byte;
               end
            end
            st_body_byte: begin
               wr_q  <= 1'b1;
               state <= st_body_next;
            end
            st_body_next: begin
               if (addr_q != last_addr) begin
                  addr_q <= addr_q + 1'b1;
                  state  <= st_body_byte;
               end else begin
                  state <= st_verdict;
               end
            end
            // fcs went in on the last write edge
            st_verdict: begin
               if (crc_value == eth_rx_pkg::eth_crc_residue) begin
                  frame_ok <= 1'b1;
                  state    <= st_hold;
               end else begin
                  state <= st_hunt;
               end
            end
            // line ignored until the system acks
            st_hold: begin
               if (ack_sync) begin
                  frame_ok <= 1'b0;
                  state    <= st_hunt;
               end
            end
            default: state <= st_hunt;
         endcase
      end
   end

   assign rx_wr.addr = addr_q;
   assign rx_wr.data = byte_q;
   assign rx_wr.wr   = wr_q;

   assign crc_start = (state == st_hunt);

   a_wr_states: assert property (@(posedge RX_CLK) disable iff (rx_rst_sync)
      state inside {st_hunt, st_sync, st_verdict, st_hold} |-> !rx_wr.wr);

   // writes stay inside the frame the system asked for
   a_addr_range: assert property (@(posedge RX_CLK) disable iff (rx_rst_sync)
      rx_wr.wr |-> rx_wr.addr <= last_addr);

endmodule

// File: hdl/eth_rx_buffer.sv
module eth_rx_buffer (
   input  logic                             RX_CLK,
   input  logic                             clk,
   input  eth_rx_pkg::rx_wr_t               rx_wr,
   input  logic [eth_rx_pkg::eth_buf_aw-1:0] rd_addr,
   output logic [7:0]                       rd_data
);

   logic [7:0] mem [0:(1 << eth_rx_pkg::eth_buf_aw)-1];

   always_ff @(posedge RX_CLK) begin
      if (rx_wr.wr) begin
         mem[rx_wr.addr] <= rx_wr.data;
      end
   end

   // system side read, one clk of latency
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

   a_wr_addr_known: assert property (@(posedge RX_CLK)
      rx_wr.wr |-> !$isunknown(rx_wr.addr));

endmodule

// File: hdl/eth_rx_top.sv
module eth_rx_top (
   input  logic                             RX_CLK,
   input  logic                             clk,
   input  logic                             rx_rst,
   input  logic                             RX_DV,
   input  logic [3:0]                       RX_DATA,
   input  logic [eth_rx_pkg::eth_buf_aw-1:0] nbytes,
   input  logic                             rcv_ack,
   input  logic [eth_rx_pkg::eth_buf_aw-1:0] rd_addr,
   output logic                             data_rcvd,
   output logic [7:0]                       rd_data
);

   logic                               rx_rst_sync;
   logic                               ack_sync;
   logic [eth_rx_pkg::eth_buf_aw-1:0] nbytes_rx;
   logic                               frame_ok;
   logic                               crc_start;
   logic [31:0]                        crc_value;
   eth_rx_pkg::rx_wr_t                 rx_wr;

   eth_rx_cdc cdc0 (
      .RX_CLK      (RX_CLK),
      .clk         (clk),
      .rx_rst      (rx_rst),
      .rcv_ack     (rcv_ack),
      .nbytes      (nbytes),
      .frame_ok    (frame_ok),
      .rx_rst_sync (rx_rst_sync),
      .ack_sync    (ack_sync),
      .nbytes_rx   (nbytes_rx),
      .data_rcvd   (data_rcvd)
   );

   eth_frame_rx rx0 (
      .RX_CLK      (RX_CLK),
      .rx_rst_sync (rx_rst_sync),
      .RX_DV       (RX_DV),
      .RX_DATA     (RX_DATA),
      .nbytes_rx   (nbytes_rx),
      .ack_sync    (ack_sync),
      .crc_value   (crc_value),
      .rx_wr       (rx_wr),
      .crc_start   (crc_start),
      .frame_ok    (frame_ok)
   );

   // crc runs on the same byte strobe as the buffer
   eth_crc32 crc0 (
      .RX_CLK      (RX_CLK),
      .rx_rst_sync (rx_rst_sync),
      .crc_start   (crc_start),
      .crc_en      (rx_wr.wr),
      .crc_byte    (rx_wr.data),
      .crc_value   (crc_value)
   );

   eth_rx_buffer buf0 (
      .RX_CLK  (RX_CLK),
      .clk     (clk),
      .rx_wr   (rx_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// File: sim/tb_eth_rx.sv
module tb_eth_rx;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int rec_bytes = 21;
   localparam int max_recs = 16;
   localparam int hdr = eth_rx_pkg::eth_hdr_bytes;
   localparam int fcs_len = eth_rx_pkg::eth_fcs_bytes;

   logic                              RX_CLK, clk, rx_rst, RX_DV, rcv_ack, data_rcvd;
   logic [3:0]                        RX_DATA;
   logic [eth_rx_pkg::eth_buf_aw-1:0] nbytes, rd_addr;
   logic [7:0]                        rd_data;

   logic [7:0] tdata [0:rec_bytes*max_recs-1];
   logic [7:0] tx_bytes [0:2047];
   logic [7:0] exp_bytes [0:2047];
   int         tx_len, exp_len;
   int         errors, test_errs, tests_run, tests_failed;
   integer     seed;
   string      test_name;

   eth_rx_top dut0 (
      .RX_CLK    (RX_CLK),
      .clk       (clk),
      .rx_rst    (rx_rst),
      .RX_DV     (RX_DV),
      .RX_DATA   (RX_DATA),
      .nbytes    (nbytes),
      .rcv_ack   (rcv_ack),
      .rd_addr   (rd_addr),
      .data_rcvd (data_rcvd),
      .rd_data   (rd_data)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #5 RX_CLK = ~RX_CLK;
   end

   initial begin
      clk = 1'b0;
      forever #7 clk = ~clk;
   end

   function automatic string name_of(input logic [7:0] tag);
      case (tag)
         8'd1: return "good_frame";
         8'd2: return "foreign_dst";
         8'd3: return "bad_fcs";
         8'd4: return "ack_hold";
         8'd5: return "payload_len";
         8'd6: return "mid_reset";
         default: return "unknown";
      endcase
   endfunction

   // reflected form with poly edb88320 over tx_bytes
   function automatic logic [31:0] frame_crc(input int len);
      logic [31:0] c;
      c = 32'hffff_ffff;
      for (int i = 0; i < len; i++) begin
         c = c ^ {24'h0, tx_bytes[i]};
         for (int j = 0; j < 8; j++) begin
            if (c[0]) begin
               c = (c >> 1) ^ 32'hedb8_8320;
            end else begin
               c = c >> 1;
            end
         end
      end
      return c;
   endfunction

   task automatic note_error();
      errors++;
      test_errs++;
   endtask

   task automatic report_test(input logic [7:0] tag);
      tests_run++;
      if (test_errs == 0) begin
         $display("test %0d %s: ok", tag, name_of(tag));
      end else begin
         $display("test %0d %s: failed with %0d errors", tag, name_of(tag), test_errs);
         tests_failed++;
      end
      test_errs = 0;
   endtask

   task automatic build_frame(input int base);
      int          n;
      logic [31:0] fcs;
      n = {tdata[base+3], tdata[base+4]};
      for (int i = 0; i < hdr; i++) begin
         tx_bytes[i] = tdata[base+7+i];
      end
      // pattern covers every bit of the payload index
      for (int i = 0; i < n; i++) begin
         tx_bytes[hdr+i] = (tdata[base+6] + i[7:0]) ^ i[15:8];
      end
      fcs = ~frame_crc(hdr + n);
      for (int k = 0; k < fcs_len; k++) begin
         tx_bytes[hdr+n+k] = fcs[8*k +: 8];
      end
      tx_bytes[hdr+n] = tx_bytes[hdr+n] ^ tdata[base+5];
      tx_len = hdr + n + fcs_len;
   endtask

   task automatic drive_nibble(input logic dv, input logic [3:0] n);
      @(posedge RX_CLK);
      #1;
      RX_DV   = dv;
      RX_DATA = n;
   endtask

   task automatic send_byte(input logic [7:0] b);
      drive_nibble(1'b1, b[3:0]);
      drive_nibble(1'b1, b[7:4]);
   endtask

   // cut > 0 stops after that many bytes with RX_DV still high
   task automatic send_frame(input int cut);
      int count;
      count = (cut > 0) ? cut : tx_len;
      for (int i = 0; i < 7; i++) begin
         send_byte(8'h55);
      end
      send_byte(eth_rx_pkg::eth_sfd);
      for (int i = 0; i < count; i++) begin
         send_byte(tx_bytes[i]);
      end
      if (cut == 0) begin
         drive_nibble(1'b0, 4'h0);
      end
   endtask

   task automatic idle_gap(input logic [15:0] n);
      int cycles;
      cycles = 12 + ($unsigned($random(seed)) % 16);
      @(posedge RX_CLK);
      #1;
      nbytes  = n[eth_rx_pkg::eth_buf_aw-1:0];
      RX_DV   = 1'b0;
      RX_DATA = 4'h0;
      repeat (cycles) @(posedge RX_CLK);
   endtask

   task automatic apply_reset();
      @(posedge RX_CLK);
      #1;
      rx_rst  = 1'b1;
      RX_DV   = 1'b0;
      RX_DATA = 4'h0;
      repeat (8) @(posedge RX_CLK);
      #1;
      rx_rst = 1'b0;
   endtask

   task automatic wait_level(input logic level, input int limit, output bit seen);
      int i;
      seen = 1'b0;
      i = 0;
      while (!seen && i < limit) begin
         @(posedge clk);
         #1;
         if (data_rcvd === level) begin
            seen = 1'b1;
         end
         i++;
      end
      if (!seen) begin
         $display("timeout: data_rcvd did not go to %0b within %0d clk cycles in %s",
                  level, limit, test_name);
         note_error();
      end
   endtask

   // fixed window in which the flag must not rise
   task automatic watch_low(input int limit);
      logic seen_val;
      seen_val = 1'b0;
      for (int i = 0; i < limit; i++) begin
         @(posedge clk);
         #1;
         if (data_rcvd !== 1'b0) begin
            seen_val = data_rcvd;
         end
      end
      assert (seen_val === 1'b0) else begin
         $display("error %s: data_rcvd expected 0 actual %b", test_name, seen_val);
         note_error();
      end
   endtask

   task automatic ack_frame();
      bit seen;
      @(posedge clk);
      #1;
      rcv_ack = 1'b1;
      @(posedge clk);
      #1;
      rcv_ack = 1'b0;
      wait_level(1'b0, 20, seen);
   endtask

   task automatic check_buffer();
      for (int a = 0; a < exp_len; a++) begin
         @(posedge clk);
         #1;
         rd_addr = a[eth_rx_pkg::eth_buf_aw-1:0];
         @(posedge clk);
         #1;
         assert (rd_data === exp_bytes[a]) else begin
            $display("error %s: buffer[%0d] expected %02h actual %02h",
                     test_name, a, exp_bytes[a], rd_data);
            note_error();
         end
      end
   endtask

   initial begin
      int         base;
      int         mode;
      bit         seen;
      logic [7:0] tag;
      logic [7:0] cur_tag;
      seed    = 32'h746e;
      rx_rst  = 1'b1;
      RX_DV   = 1'b0;
      RX_DATA = 4'h0;
      nbytes  = '0;
      rcv_ack = 1'b0;
      rd_addr = '0;
      errors  = 0;
      test_errs    = 0;
      tests_run    = 0;
      tests_failed = 0;
      $readmemh("sim/eth_rx_testdata.hex", tdata);
      apply_reset();
      test_name = "after_reset";
      @(posedge clk);
      #1;
      assert (data_rcvd === 1'b0) else begin
         $display("error %s: data_rcvd expected 0 actual %b", test_name, data_rcvd);
         note_error();
      end
      cur_tag = tdata[0];
      for (int r = 0; r < max_recs; r++) begin
         base = r * rec_bytes;
         tag  = tdata[base];
         if (tag === 8'hff || $isunknown(tag)) begin
            break;
         end
         if (tag != cur_tag) begin
            report_test(cur_tag);
            cur_tag = tag;
         end
         test_name = name_of(tag);
         mode = tdata[base+1];
         build_frame(base);
         idle_gap({tdata[base+3], tdata[base+4]});
         if (mode == 3) begin
            send_frame(tx_len / 2);
            apply_reset();
            @(posedge clk);
            #1;
            assert (data_rcvd === 1'b0) else begin
               $display("error %s: data_rcvd expected 0 actual %b", test_name, data_rcvd);
               note_error();
            end
         end else begin
            send_frame(0);
            if (tdata[base+2] == 8'h01) begin
               wait_level(1'b1, 200, seen);
               if (seen) begin
                  for (int i = 0; i < tx_len; i++) begin
                     exp_bytes[i] = tx_bytes[i];
                  end
                  exp_len = tx_len;
                  check_buffer();
               end
               if (mode == 0) begin
                  ack_frame();
               end
            end else if (mode == 2) begin
               // still held from the earlier frame so the buffer is untouched
               assert (data_rcvd === 1'b1) else begin
                  $display("error %s: data_rcvd expected 1 actual %b", test_name, data_rcvd);
                  note_error();
               end
               check_buffer();
               ack_frame();
            end else begin
               watch_low(60);
            end
         end
      end
      report_test(cur_tag);
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: all.f
hdl/eth_rx_pkg.sv
hdl/eth_rx_cdc.sv
hdl/eth_crc32.sv
hdl/eth_frame_rx.sv
hdl/eth_rx_buffer.sv
hdl/eth_rx_top.sv
sim/tb_eth_rx.sv

// File: Bender.yml
package:
  name: eth_rx

sources:
  - target: rtl
    files:
      - hdl/eth_rx_pkg.sv
      - hdl/eth_rx_cdc.sv
      - hdl/eth_crc32.sv
      - hdl/eth_frame_rx.sv
      - hdl/eth_rx_buffer.sv
      - hdl/eth_rx_top.sv
  - target: simulation
    files:
      - hdl/eth_rx_pkg.sv
      - hdl/eth_rx_cdc.sv
      - hdl/eth_crc32.sv
      - hdl/eth_frame_rx.sv
      - hdl/eth_rx_buffer.sv
      - hdl/eth_rx_top.sv
      - sim/tb_eth_rx.sv

// File: sim/eth_rx_testdata.hex
// tag mode expect nbytes_hi nbytes_lo fcs_xor seed, then dst mac, src mac, type
// mode 0 ack, 1 keep held, 2 sent while held, 3 reset mid-frame; tag ff ends the list
// payload bytes follow a pattern from seed, fcs is appended by the testbench
// test 1, good frame
01 00 01 00 2e 00 10  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
// test 2, foreign destination then a good frame
02 00 00 00 40 00 20  02 12 34 56 78 9b  0a 1b 2c 3d 4e 5f  08 00
02 00 01 00 40 00 30  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
// test 3, corrupted fcs then a good frame
03 00 00 00 30 40 40  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
03 00 01 00 30 00 50  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
// test 4, held frame, second frame lost until ack
04 01 01 00 3c 00 60  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
04 02 00 00 3c 00 70  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
// test 5, payload lengths 46, 1, 300, 1500
05 00 01 00 2e 00 80  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
05 00 01 00 01 00 90  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
05 00 01 01 2c 00 a0  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
05 00 01 05 dc 00 b0  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
// test 6, reset mid-frame then a good frame
06 03 00 00 80 00 c0  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
06 00 01 00 40 00 d0  02 12 34 56 78 9a  0a 1b 2c 3d 4e 5f  08 00
ff
